// File: include/fp_sqrt_defines.svh
// Binary32 field widths and the root iteration count
`ifndef FP_SQRT_DEFINES_SVH
`define FP_SQRT_DEFINES_SVH

// Exponent and stored significand widths of IEEE-754 binary32
`define FP_EXP_W 8
`define FP_SIG_W 23

// One root bit per iteration, hidden bit included
`define SQRT_ITER 24

`endif

// File: verilog/fp_sqrt_pkg.sv
// Float and round-bit types, canonical NaN constant and square-root FSM states
package fp_sqrt_pkg;

    `include "fp_sqrt_defines.svh"

    // Single precision operand split into its three fields
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exponent;
        logic [`FP_SIG_W-1:0] significand;
    } float32_t;

    // Bits below the result LSB, in order of weight
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Quiet NaN returned for every invalid operation
    localparam float32_t CANONICAL_NAN = '{
        sign:        1'b0,
        exponent:    '1,
        significand: {1'b1, {(`FP_SIG_W - 1){1'b0}}}
    };

    // Control states of the square-root unit
    typedef enum logic [1:0] {
        IDLE,
        SQRT,
        VALID
    } sqrt_state_t;

endpackage : fp_sqrt_pkg

// File: verilog/count_leading_zeros.sv
// Parameterized combinational leading-zero counter built from halving priority stages
`timescale 1ns/1ns

module count_leading_zeros #(
    parameter int  CLZ_W = 24,
    localparam int CNT_W = $clog2(CLZ_W + 1)
) (
    input  logic [CLZ_W-1:0] operand_i,
    output logic [CNT_W-1:0] lz_count_o,
    output logic             is_all_zero_o
);

    // The operand is left aligned in a power-of-two window
    localparam int LEVELS = $clog2(CLZ_W);
    localparam int PAD_W  = 1 << LEVELS;

    logic [PAD_W-1:0]  window;
    logic [LEVELS-1:0] tree_cnt;

    // Each stage looks at the upper half of what is left of the window.
    // When that half is all zero its width is a bit of the count and it is shifted out
    always_comb begin
        window   = PAD_W'(operand_i) << (PAD_W - CLZ_W);
        tree_cnt = '0;
        for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
            if ((window >> (PAD_W - (1 << lvl))) == '0) begin
                tree_cnt[lvl] = 1'b1;
                window        = window << (1 << lvl);
            end
        end
    end

    assign is_all_zero_o = operand_i == '0;

    // The tree saturates on a zero operand, so the full width is reported instead
    assign lz_count_o = is_all_zero_o ? CNT_W'(CLZ_W) : CNT_W'(tree_cnt);

endmodule : count_leading_zeros

// File: verilog/non_restoring_square_root.sv
// Sequential non-restoring integer square root, one root bit per enabled cycle
`timescale 1ns/1ns

module non_restoring_square_root #(
    parameter int RADICAND_W = 48
) (
    input  logic                    clk_i,
    input  logic                    clk_en_i,
    input  logic                    rst_n_i,
    input  logic                    data_valid_i,
    input  logic [RADICAND_W-1:0]   radicand_i,
    output logic [RADICAND_W/2-1:0] root_o,
    output logic [RADICAND_W/2:0]   remainder_o,
    output logic                    data_valid_o,
    output logic                    idle_o
);

    localparam int ROOT_W = RADICAND_W / 2;
    localparam int REM_W  = ROOT_W + 2;
    localparam int CNT_W  = $clog2(ROOT_W + 1);

    // Iteration state
    logic                  busy_q;
    logic [CNT_W-1:0]      iter_cnt_q;
    logic [RADICAND_W-1:0] rad_q;
    logic [REM_W-1:0]      rem_q;
    logic [ROOT_W-1:0]     root_q;

    // One iteration step
    logic                  start;
    logic                  last_iter;
    logic [RADICAND_W-1:0] rad_src;
    logic [REM_W-1:0]      rem_src;
    logic [ROOT_W-1:0]     root_src;
    logic [REM_W-1:0]      rem_shifted;
    logic [REM_W-1:0]      rem_next;
    logic [ROOT_W-1:0]     root_next;
    logic [REM_W-1:0]      rem_fixed;

    // A strobe while busy is dropped
    assign start  = data_valid_i & ~busy_q;
    assign idle_o = ~busy_q;

    // The load cycle already runs the first iteration, so the counter only covers the rest
    assign last_iter = busy_q & (iter_cnt_q == CNT_W'(1));

    // ----------------------------------------------------------------------
    // Iteration datapath
    // ----------------------------------------------------------------------

    always_comb begin
        // On the start cycle the step works straight from the new radicand
        rad_src  = start ? radicand_i : rad_q;
        rem_src  = start ? '0 : rem_q;
        root_src = start ? '0 : root_q;

        // Bring down the next two radicand bits
        rem_shifted = {rem_src[REM_W-3:0], rad_src[RADICAND_W-1 -: 2]};

        // A positive partial remainder subtracts 4Q+1, a negative one adds 4Q+3
        if (!rem_src[REM_W-1]) begin
            rem_next = rem_shifted - REM_W'({root_src, 2'b01});
        end else begin
            rem_next = rem_shifted + REM_W'({root_src, 2'b11});
        end

        // The new root bit is set when the remainder stayed non-negative
        root_next = {root_src[ROOT_W-2:0], ~rem_next[REM_W-1]};

        // A final negative remainder is brought back by adding 2Q+1
        if (rem_next[REM_W-1]) begin
            rem_fixed = rem_next + REM_W'({root_next, 1'b1});
        end else begin
            rem_fixed = rem_next;
        end
    end

    // ----------------------------------------------------------------------
    // Control and result registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            iter_cnt_q   <= '0;
            data_valid_o <= 1'b0;
        end else if (clk_en_i) begin
            data_valid_o <= 1'b0;
            if (start) begin
                busy_q     <= 1'b1;
                iter_cnt_q <= CNT_W'(ROOT_W - 1);
            end else if (busy_q) begin
                iter_cnt_q <= iter_cnt_q - CNT_W'(1);
                if (last_iter) begin
                    busy_q       <= 1'b0;
                    data_valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i && (start || busy_q)) begin
            rad_q  <= rad_src << 2;
            rem_q  <= rem_next;
            root_q <= root_next;
            // Outputs hold the last result until the next operation ends
            if (last_iter) begin
                root_o      <= root_next;
                remainder_o <= rem_fixed[ROOT_W:0];
            end
        end
    end

endmodule : non_restoring_square_root

// File: verilog/floating_point_square_root.sv
// Square-root control FSM with classification, normalization and round-bit generation
`timescale 1ns/1ns
`include "fp_sqrt_defines.svh"

module floating_point_square_root #(
    parameter int RADICAND_W = 48,
    parameter int CLZ_W      = 24
) (
    input  logic                     clk_i,
    input  logic                     clk_en_i,
    input  logic                     rst_n_i,
    input  fp_sqrt_pkg::float32_t    radicand_i,
    input  logic                     data_valid_i,
    output fp_sqrt_pkg::float32_t    unrounded_o,
    output fp_sqrt_pkg::round_bits_t round_bits_o,
    output logic                     invalid_o,
    output logic                     bypass_o,
    output logic                     data_valid_o
);

    import fp_sqrt_pkg::*;

    localparam int LZ_W   = $clog2(CLZ_W + 1);
    localparam int EXP_W  = `FP_EXP_W + 2;
    localparam int SIG_W  = CLZ_W + 1;
    localparam int ROOT_W = `SQRT_ITER;
    localparam int CMP_W  = ROOT_W + 2;

    // ----------------------------------------------------------------------
    // Classification and normalization of the incoming operand
    // ----------------------------------------------------------------------

    logic exp_zero;
    logic exp_ones;
    logic sig_zero;
    logic is_zero;
    logic is_pos_inf;
    logic is_nan;
    logic is_negative;

    assign exp_zero    = radicand_i.exponent == '0;
    assign exp_ones    = radicand_i.exponent == '1;
    assign sig_zero    = radicand_i.significand == '0;
    assign is_pos_inf  = exp_ones & sig_zero & ~radicand_i.sign;
    assign is_nan      = exp_ones & ~sig_zero;
    // Negative zero is not negative for a square root
    assign is_negative = radicand_i.sign & ~is_zero;

    logic [CLZ_W-1:0] full_sig;
    logic [LZ_W-1:0]  lz_count;
    logic [CLZ_W-1:0] norm_sig;
    logic [EXP_W-1:0] unbiased_exp;
    logic [EXP_W-1:0] even_exp;
    logic [SIG_W-1:0] even_sig;

    // Hidden bit is set for normal numbers only
    assign full_sig = {~exp_zero, radicand_i.significand};

    count_leading_zeros #(
        .CLZ_W(CLZ_W)
    ) u_clz (
        .operand_i    (full_sig),
        .lz_count_o   (lz_count),
        .is_all_zero_o(is_zero)
    );

    // Normals have no leading zeros, so the shift only moves subnormals
    assign norm_sig = full_sig << lz_count;

    // Subnormals sit at exponent -126 and lose one more for every leading zero
    always_comb begin
        if (exp_zero) begin
            unbiased_exp = EXP_W'(-126) - EXP_W'(lz_count);
        end else begin
            unbiased_exp = EXP_W'(radicand_i.exponent) - EXP_W'(127);
        end
    end

    // An odd exponent loses one and the significand doubles in exchange
    assign even_exp = {unbiased_exp[EXP_W-1:1], 1'b0};
    assign even_sig = unbiased_exp[0] ? {norm_sig, 1'b0} : {1'b0, norm_sig};

    // ----------------------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------------------

    sqrt_state_t state_q;
    sqrt_state_t state_d;
    logic        start_q;
    logic        capture;
    logic        core_idle;
    logic        core_valid;

    assign capture = (state_q == IDLE) & data_valid_i & core_idle;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (capture) begin
                    state_d = SQRT;
                end
            end
            SQRT: begin
                if (core_valid) begin
                    state_d = VALID;
                end
            end
            VALID: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // The core start pulse trails the capture by one enabled cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            start_q <= 1'b0;
        end else if (clk_en_i) begin
            state_q <= state_d;
            start_q <= capture;
        end
    end

    // ----------------------------------------------------------------------
    // Operand latch, root core and round bits
    // ----------------------------------------------------------------------

    float32_t               operand_q;
    logic                   invalid_q;
    logic                   bypass_q;
    logic [EXP_W-1:0]       exp_q;
    logic [SIG_W-1:0]       sig_q;
    logic [`FP_SIG_W-1:0]   root_q;
    round_bits_t            round_q;
    logic [RADICAND_W-1:0]  core_radicand;
    logic [ROOT_W-1:0]      core_root;
    logic [ROOT_W:0]        core_rem;

    // The even significand goes to the top of the radicand so the root has ROOT_W bits
    assign core_radicand = RADICAND_W'(sig_q) << (RADICAND_W - SIG_W);

    non_restoring_square_root #(
        .RADICAND_W(RADICAND_W)
    ) u_core (
        .clk_i       (clk_i),
        .clk_en_i    (clk_en_i),
        .rst_n_i     (rst_n_i),
        .data_valid_i(start_q),
        .radicand_i  (core_radicand),
        .root_o      (core_root),
        .remainder_o (core_rem),
        .data_valid_o(core_valid),
        .idle_o      (core_idle)
    );

    logic [CMP_W-1:0] rem_ext;
    logic [CMP_W-1:0] root_ext;
    logic [CMP_W-1:0] half_root;
    logic [CMP_W-1:0] upper_thresh;
    logic             guard_bit;
    logic             round_bit;
    logic             sticky_bit;

    assign rem_ext      = CMP_W'(core_rem);
    assign root_ext     = CMP_W'(core_root);
    assign half_root    = root_ext >> 1;
    assign upper_thresh = root_ext + half_root + CMP_W'(core_root[0]);

    // With R = Q*Q + rem, the fraction of the root passes one half when rem exceeds Q.
    // The quarter points sit at Q/2 and 3Q/2 after integer rounding of the bounds
    assign guard_bit  = rem_ext > root_ext;
    assign round_bit  = guard_bit ? (rem_ext > upper_thresh) : (rem_ext > half_root);
    // An integer that is not a perfect square has an irrational root
    assign sticky_bit = rem_ext != '0;

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            if (capture) begin
                operand_q <= radicand_i;
                invalid_q <= is_nan | is_negative;
                bypass_q  <= is_zero | is_pos_inf | is_nan | is_negative;
                exp_q     <= even_exp;
                sig_q     <= even_sig;
            end
            if ((state_q == SQRT) && core_valid) begin
                root_q  <= core_root[`FP_SIG_W-1:0];
                round_q <= '{guard: guard_bit, round: round_bit, sticky: sticky_bit};
            end
        end
    end

    // ----------------------------------------------------------------------
    // Unrounded result
    // ----------------------------------------------------------------------

    logic [EXP_W-1:0] result_exp;

    // Arithmetic halving of the even exponent, then the bias goes back on
    assign result_exp = {exp_q[EXP_W-1], exp_q[EXP_W-1:1]} + EXP_W'(127);

    always_comb begin
        if (invalid_q) begin
            unrounded_o = CANONICAL_NAN;
        end else if (bypass_q) begin
            unrounded_o = operand_q;
        end else begin
            unrounded_o.sign        = 1'b0;
            unrounded_o.exponent    = result_exp[`FP_EXP_W-1:0];
            unrounded_o.significand = root_q;
        end
    end

    assign round_bits_o = round_q;
    assign invalid_o    = invalid_q;
    assign bypass_o     = bypass_q;
    assign data_valid_o = state_q == VALID;

endmodule : floating_point_square_root

// File: verilog/fp_rounding_stage.sv
// Round-to-nearest-even register stage with invalid and inexact flags
`timescale 1ns/1ns
`include "fp_sqrt_defines.svh"

module fp_rounding_stage (
    input  logic                     clk_i,
    input  logic                     clk_en_i,
    input  logic                     rst_n_i,
    input  fp_sqrt_pkg::float32_t    unrounded_i,
    input  fp_sqrt_pkg::round_bits_t round_bits_i,
    input  logic                     invalid_i,
    input  logic                     bypass_i,
    input  logic                     data_valid_i,
    output fp_sqrt_pkg::float32_t    result_o,
    output logic                     data_valid_o,
    output logic                     invalid_operation_o,
    output logic                     inexact_o
);

    import fp_sqrt_pkg::*;

    localparam int SIG_W = `FP_SIG_W;
    localparam int EXP_W = `FP_EXP_W;

    logic             round_up;
    logic             any_round_bit;
    logic [SIG_W:0]   sig_sum;
    logic [EXP_W-1:0] exp_sum;
    float32_t         rounded;

    // Ties go to the even significand
    assign round_up = round_bits_i.guard &
                      (round_bits_i.round | round_bits_i.sticky | unrounded_i.significand[0]);

    assign any_round_bit = round_bits_i.guard | round_bits_i.round | round_bits_i.sticky;

    // A carry out of the significand leaves it zero and bumps the exponent
    assign sig_sum = {1'b0, unrounded_i.significand} + (SIG_W + 1)'(round_up);
    assign exp_sum = unrounded_i.exponent + EXP_W'(sig_sum[SIG_W]);

    always_comb begin
        if (bypass_i) begin
            rounded = unrounded_i;
        end else begin
            rounded.sign        = unrounded_i.sign;
            rounded.exponent    = exp_sum;
            rounded.significand = sig_sum[SIG_W-1:0];
        end
    end

    // Flags are pulses aligned with the output valid
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_o        <= 1'b0;
            invalid_operation_o <= 1'b0;
            inexact_o           <= 1'b0;
        end else if (clk_en_i) begin
            data_valid_o        <= data_valid_i;
            invalid_operation_o <= data_valid_i & invalid_i;
            inexact_o           <= data_valid_i & ~bypass_i & any_round_bit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i && data_valid_i) begin
            result_o <= rounded;
        end
    end

endmodule : fp_rounding_stage

// File: verilog/fp_sqrt_top.sv
// Top level of the square-root unit and its rounding stage
`timescale 1ns/1ns

module fp_sqrt_top #(
    parameter int RADICAND_W = 48,
    parameter int CLZ_W      = 24
) (
    input  logic                  clk_i,
    input  logic                  clk_en_i,
    input  logic                  rst_n_i,
    input  fp_sqrt_pkg::float32_t radicand_i,
    input  logic                  data_valid_i,
    output fp_sqrt_pkg::float32_t result_o,
    output logic                  data_valid_o,
    output logic                  invalid_operation_o,
    output logic                  inexact_o
);

    import fp_sqrt_pkg::*;

    // Unrounded result handed to the rounding stage
    float32_t    unrounded;
    round_bits_t round_bits;
    logic        invalid;
    logic        bypass;
    logic        unrounded_valid;

    floating_point_square_root #(
        .RADICAND_W(RADICAND_W),
        .CLZ_W     (CLZ_W)
    ) u_sqrt (
        .clk_i       (clk_i),
        .clk_en_i    (clk_en_i),
        .rst_n_i     (rst_n_i),
        .radicand_i  (radicand_i),
        .data_valid_i(data_valid_i),
        .unrounded_o (unrounded),
        .round_bits_o(round_bits),
        .invalid_o   (invalid),
        .bypass_o    (bypass),
        .data_valid_o(unrounded_valid)
    );

    fp_rounding_stage u_round (
        .clk_i              (clk_i),
        .clk_en_i           (clk_en_i),
        .rst_n_i            (rst_n_i),
        .unrounded_i        (unrounded),
        .round_bits_i       (round_bits),
        .invalid_i          (invalid),
        .bypass_i           (bypass),
        .data_valid_i       (unrounded_valid),
        .result_o           (result_o),
        .data_valid_o       (data_valid_o),
        .invalid_operation_o(invalid_operation_o),
        .inexact_o          (inexact_o)
    );

endmodule : fp_sqrt_top

// File: testbench/fp_sqrt_tb.sv
// Testbench for the square-root unit with clock, reset, stimulus, reference model and assertions
`timescale 1ns/1ns

module fp_sqrt_tb;

    import fp_sqrt_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int LATENCY    = 27;
    localparam int WAIT_LIMIT = 200;
    // Cycle of the wait at which a clock-enable stall begins
    localparam int STALL_AT   = 10;
    // Cycle at which a second operand is offered while the unit is busy
    localparam int INTRUDE_AT = 5;
    localparam logic [31:0] INTRUDER = 32'h4110_0000;

    logic     clk_i;
    logic     rst_n_i;
    logic     clk_en_i;
    float32_t radicand_i;
    logic     data_valid_i;
    float32_t result_o;
    logic     data_valid_o;
    logic     invalid_operation_o;
    logic     inexact_o;

    // Expected response of the operation in flight
    float32_t expected_result;
    logic     expected_invalid;
    logic     expected_inexact;
    logic     expect_normal;
    logic     valid_allowed;
    float32_t current_operand;

    int errors;
    int timeouts;
    int seed;

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    fp_sqrt_top #(
        .RADICAND_W(48),
        .CLZ_W     (24)
    ) fp_sqrt_top_inst (
        .clk_i              (clk_i),
        .clk_en_i           (clk_en_i),
        .rst_n_i            (rst_n_i),
        .radicand_i         (radicand_i),
        .data_valid_i       (data_valid_i),
        .result_o           (result_o),
        .data_valid_o       (data_valid_o),
        .invalid_operation_o(invalid_operation_o),
        .inexact_o          (inexact_o)
    );

    // ----------------------------------------------------------------------
    // Output checks
    // ----------------------------------------------------------------------

    result_matches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o |-> result_o == expected_result)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: result %h, expected %h for operand %h",
                 $time, $sampled(result_o), expected_result, current_operand);
    end

    invalid_matches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o |-> invalid_operation_o == expected_invalid)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: invalid flag %b, expected %b for operand %h",
                 $time, $sampled(invalid_operation_o), expected_invalid, current_operand);
    end

    inexact_matches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o |-> inexact_o == expected_inexact)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: inexact flag %b, expected %b for operand %h",
                 $time, $sampled(inexact_o), expected_inexact, current_operand);
    end

    // A finite positive operand always has a normal root
    root_is_normal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_o && expect_normal) |-> result_o.exponent != '0)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: result %h is not normal for operand %h",
                 $time, $sampled(result_o), current_operand);
    end

    flags_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !data_valid_o |-> (!invalid_operation_o && !inexact_o))
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: flag raised without data_valid_o", $time);
    end

    // Outside an operation window the output strobe must stay low
    no_stray_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !valid_allowed |-> !data_valid_o)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: data_valid_o raised with no operation pending", $time);
    end

    single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_o && clk_en_i) |=> !data_valid_o)
    else begin
        errors = errors + 1;
        $display("CHECK FAILED at %0t: data_valid_o longer than one enabled cycle", $time);
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Exact value of a binary32 pattern, subnormals included
    function automatic real float_to_real(input logic [31:0] bits);
        real mag;
        int  exp_val;
        exp_val = int'(bits[30:23]);
        if (exp_val == 0) begin
            mag = real'(bits[22:0]) * (2.0 ** (-149));
        end else begin
            mag = real'({1'b1, bits[22:0]}) * (2.0 ** (exp_val - 150));
        end
        return bits[31] ? -mag : mag;
    endfunction

    // Round a double in the normal binary32 range to nearest even
    function automatic logic [31:0] real_to_float32(input real value);
        logic [63:0] dbits;
        int          exp32;
        logic [24:0] mant;
        logic        guard;
        logic        sticky;
        dbits  = $realtobits(value);
        exp32  = int'(dbits[62:52]) - 1023 + 127;
        mant   = {2'b01, dbits[51:29]};
        guard  = dbits[28];
        sticky = dbits[27:0] != '0;
        if (guard && (sticky || mant[0])) begin
            mant = mant + 25'd1;
        end
        if (mant[24]) begin
            mant  = mant >> 1;
            exp32 = exp32 + 1;
        end
        return {dbits[63], exp32[7:0], mant[22:0]};
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------

    // Offers one operand and waits for the output strobe, counting sampled cycles
    task automatic drive_and_wait(input float32_t operand, input int stall_len,
                                  input logic intrude);
        int   cycles;
        logic seen;
        cycles          = 0;
        seen            = 1'b0;
        current_operand = operand;
        @(posedge clk_i);
        radicand_i   <= operand;
        data_valid_i <= 1'b1;
        clk_en_i     <= 1'b1;
        // This edge captures the operand
        @(posedge clk_i);
        data_valid_i  <= 1'b0;
        valid_allowed = 1'b1;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
            if (data_valid_o) begin
                seen = 1'b1;
            end else begin
                @(posedge clk_i);
                clk_en_i     <= !(cycles >= STALL_AT && cycles < STALL_AT + stall_len);
                data_valid_i <= intrude && (cycles == INTRUDE_AT);
                if (intrude && (cycles == INTRUDE_AT)) begin
                    radicand_i <= INTRUDER;
                end
            end
        end
        if (!seen) begin
            timeouts = timeouts + 1;
            $display("ERROR: no data_valid_o within %0d cycles for operand %h",
                     WAIT_LIMIT, operand);
        end else begin
            assert (cycles == LATENCY + stall_len) else begin
                errors = errors + 1;
                $display("CHECK FAILED at %0t: latency %0d cycles, expected %0d",
                         $time, cycles, LATENCY + stall_len);
            end
            // The assertions sample the strobe on the next edge before the window closes
            @(posedge clk_i);
        end
        valid_allowed = 1'b0;
    endtask

    task automatic modeled_root_case(input float32_t operand, input int stall_len,
                                     input logic intrude);
        real op_val;
        real root_val;
        op_val           = float_to_real(operand);
        expected_result  = real_to_float32($sqrt(op_val));
        root_val         = float_to_real(expected_result);
        expected_invalid = 1'b0;
        // The square of a 24 bit root is exact in double precision
        expected_inexact = (root_val * root_val) != op_val;
        expect_normal    = 1'b1;
        drive_and_wait(operand, stall_len, intrude);
    endtask

    task automatic special_value_case(input float32_t operand, input float32_t result,
                                      input logic invalid);
        expected_result  = result;
        expected_invalid = invalid;
        expected_inexact = 1'b0;
        expect_normal    = 1'b0;
        drive_and_wait(operand, 0, 1'b0);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        float32_t    operand;
        logic [22:0] sig;
        int          stall_len;
        seed             = 10996;
        errors           = 0;
        timeouts         = 0;
        rst_n_i          = 1'b0;
        clk_en_i         = 1'b1;
        data_valid_i     = 1'b0;
        radicand_i       = '0;
        valid_allowed    = 1'b0;
        expected_result  = '0;
        expected_invalid = 1'b0;
        expected_inexact = 1'b0;
        expect_normal    = 1'b0;
        current_operand  = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Idle outputs are watched by the assertions before the first operand
        repeat (5) @(posedge clk_i);

        // Exact squares
        modeled_root_case(32'h4080_0000, 0, 1'b0);
        modeled_root_case(32'h4010_0000, 0, 1'b0);
        modeled_root_case(32'h3f80_0000, 0, 1'b0);

        for (int i = 0; i < 24; i++) begin
            operand.sign        = 1'b0;
            operand.exponent    = 8'(1 + {$random(seed)} % 254);
            operand.significand = 23'($random(seed));
            modeled_root_case(operand, 0, 1'b0);
        end

        // Subnormals with a spread of leading zeros
        modeled_root_case(32'h0000_0001, 0, 1'b0);
        modeled_root_case(32'h007f_ffff, 0, 1'b0);
        modeled_root_case(32'h0040_0000, 0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            sig = 23'({$random(seed)} >> ({$random(seed)} % 23));
            if (sig == '0) begin
                sig = 23'd1;
            end
            modeled_root_case({9'b0, sig}, 0, 1'b0);
        end

        special_value_case(32'h0000_0000, 32'h0000_0000, 1'b0);
        special_value_case(32'h8000_0000, 32'h8000_0000, 1'b0);
        special_value_case(32'h7f80_0000, 32'h7f80_0000, 1'b0);
        special_value_case(32'hbf80_0000, CANONICAL_NAN, 1'b1);
        special_value_case(32'hff80_0000, CANONICAL_NAN, 1'b1);
        special_value_case(32'h8000_0001, CANONICAL_NAN, 1'b1);
        special_value_case(32'h7fc0_0000, CANONICAL_NAN, 1'b1);
        special_value_case(32'h7f80_0001, CANONICAL_NAN, 1'b1);
        special_value_case(32'hffc0_0000, CANONICAL_NAN, 1'b1);

        // Random clock-enable stalls in the middle of the root
        for (int i = 0; i < 4; i++) begin
            stall_len           = 1 + {$random(seed)} % 12;
            operand.sign        = 1'b0;
            operand.exponent    = 8'(1 + {$random(seed)} % 254);
            operand.significand = 23'($random(seed));
            modeled_root_case(operand, stall_len, 1'b0);
        end

        // Only the first operand may produce a result
        modeled_root_case(32'h40c8_0000, 0, 1'b1);
        repeat (40) @(posedge clk_i);
        modeled_root_case(INTRUDER, 0, 1'b0);

        $display("Check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : fp_sqrt_tb

// File: fp_sqrt.f
+incdir+include
verilog/fp_sqrt_pkg.sv
verilog/count_leading_zeros.sv
verilog/non_restoring_square_root.sv
verilog/floating_point_square_root.sv
verilog/fp_rounding_stage.sv
verilog/fp_sqrt_top.sv
testbench/fp_sqrt_tb.sv

// File: Bender.yml
package:
  name: fp_sqrt

export_include_dirs:
  - include

sources:
  - verilog/fp_sqrt_pkg.sv
  - verilog/count_leading_zeros.sv
  - verilog/non_restoring_square_root.sv
  - verilog/floating_point_square_root.sv
  - verilog/fp_rounding_stage.sv
  - verilog/fp_sqrt_top.sv
  - target: test
    files:
      - testbench/fp_sqrt_tb.sv
